//--- verilog/rv_pkg.sv
package rv_pkg;

    parameter int xlen = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_fence  = 7'b0001111  // retired as a no-op
    } opcode_e;

    // ALU function, same encoding as funct3
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srx  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     op1;
        word_t     op2;
        word_t     store_data;
        reg_addr_t rd;
        logic      wb;
        alu_op_e   alu_op;
        logic      alu_alt;  // sub / arithmetic shift
        mem_op_e   mem_op;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      wb;
        mem_op_e   mem_op;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     result;
        reg_addr_t rd;
        logic      wb;
    } mem_wb_t;

    // forwarding bus back to decode
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

endpackage

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic              ctrl_clk,
    input  rv_pkg::reg_addr_t raddr1_i,
    input  rv_pkg::reg_addr_t raddr2_i,
    output rv_pkg::word_t     rdata1_o,
    output rv_pkg::word_t     rdata2_o,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::word_t     wdata_i,
    input  logic              wen_i
);
    import rv_pkg::*;

    logic [31:1][xlen-1:0] regs;  // x0 has no storage
    logic writing;

    assign writing = wen_i && waddr_i != '0;

    // write-through so write-back and decode meet in one cycle
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (writing && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (writing && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

    always_ff @(posedge ctrl_clk) begin
        if (writing) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    a_x0_write_ignored: assert property (@(posedge ctrl_clk)
        (wen_i && waddr_i == '0) |=> $stable(regs));

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::word_t pc_reset = 32'h00100000
) (
    input  logic           ctrl_clk,
    input  logic           ctrl_reset,
    input  logic           stall_i,
    input  logic           next_stall_i,
    input  logic           jump_i,
    input  rv_pkg::word_t  jump_target_i,
    output rv_pkg::word_t  imem_addr_o,
    output logic           imem_req_o,
    input  rv_pkg::word_t  imem_data_i,
    input  logic           imem_rdy_i,
    output logic           busy_o,
    output rv_pkg::if_id_t if_id_o
);
    import rv_pkg::*;

    word_t pc_q;

    assign imem_addr_o = pc_q;
    assign imem_req_o  = 1'b1;  // always fetching
    assign busy_o      = imem_req_o && !imem_rdy_i;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            pc_q          <= pc_reset;
            if_id_o.valid <= 1'b0;
        end else if (!stall_i) begin
            pc_q    <= jump_i ? jump_target_i : pc_q + 32'd4;
            if_id_o <= '{valid: 1'b1, pc: pc_q, inst: imem_data_i};
        end else if (!next_stall_i) begin
            if_id_o.valid <= 1'b0;  // bubble
        end
    end

    // pc only moves on a completed handshake
    a_imem_addr_hold: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        (imem_req_o && !imem_rdy_i) |=> $stable(imem_addr_o));

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              ctrl_clk,
    input  logic              ctrl_reset,
    input  logic              stall_i,
    input  logic              next_stall_i,
    input  rv_pkg::if_id_t    if_id_i,
    output rv_pkg::reg_addr_t raddr1_o,
    output rv_pkg::reg_addr_t raddr2_o,
    input  rv_pkg::word_t     rdata1_i,
    input  rv_pkg::word_t     rdata2_i,
    input  rv_pkg::fwd_t      fwd_ex_i,
    input  rv_pkg::fwd_t      fwd_mem_i,
    input  logic              load_pending_i,
    output logic              jump_o,
    output rv_pkg::word_t     jump_target_o,
    output logic              busy_o,
    output rv_pkg::id_ex_t    id_ex_o
);
    import rv_pkg::*;

    opcode_e   opcode;
    logic [2:0] funct3;
    reg_addr_t rs1, rs2, rd;
    word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t     op_a, op_b, jalr_sum;
    logic      live, uses_rs1, uses_rs2, cmp, taken;
    logic      squash_q;  // slot behind a taken transfer
    id_ex_t    id_ex_d;

    assign opcode = opcode_e'(if_id_i.inst[6:0]);
    assign funct3 = if_id_i.inst[14:12];
    assign rd     = if_id_i.inst[11:7];
    assign rs1    = if_id_i.inst[19:15];
    assign rs2    = if_id_i.inst[24:20];

    assign imm_i = {{20{if_id_i.inst[31]}}, if_id_i.inst[31:20]};
    assign imm_s = {{20{if_id_i.inst[31]}}, if_id_i.inst[31:25], if_id_i.inst[11:7]};
    assign imm_b = {{20{if_id_i.inst[31]}}, if_id_i.inst[7], if_id_i.inst[30:25],
                    if_id_i.inst[11:8], 1'b0};
    assign imm_u = {if_id_i.inst[31:12], 12'b0};
    assign imm_j = {{12{if_id_i.inst[31]}}, if_id_i.inst[19:12], if_id_i.inst[20],
                    if_id_i.inst[30:21], 1'b0};

    assign raddr1_o = rs1;
    assign raddr2_o = rs2;

    // execute beats memory beats the register file
    assign op_a = (fwd_ex_i.valid && fwd_ex_i.rd == rs1) ? fwd_ex_i.data :
                  (fwd_mem_i.valid && fwd_mem_i.rd == rs1) ? fwd_mem_i.data : rdata1_i;
    assign op_b = (fwd_ex_i.valid && fwd_ex_i.rd == rs2) ? fwd_ex_i.data :
                  (fwd_mem_i.valid && fwd_mem_i.rd == rs2) ? fwd_mem_i.data : rdata2_i;

    assign live     = if_id_i.valid && !squash_q;
    assign uses_rs1 = opcode inside {opc_jalr, opc_branch, opc_load, opc_store,
                                     opc_op_imm, opc_op};
    assign uses_rs2 = opcode inside {opc_branch, opc_store, opc_op};

    // load in execute, value only ready from memory next cycle
    assign busy_o = live && load_pending_i &&
                    ((uses_rs1 && fwd_ex_i.rd == rs1) || (uses_rs2 && fwd_ex_i.rd == rs2));

    always_comb begin
        case (funct3[2:1])
            2'b00:   cmp = op_a == op_b;                    // beq / bne
            2'b10:   cmp = $signed(op_a) < $signed(op_b);   // blt / bge
            default: cmp = op_a < op_b;                     // bltu / bgeu
        endcase
    end
    assign taken = cmp ^ funct3[0];

    assign jalr_sum = op_a + imm_i;
    assign jump_o = live && (opcode == opc_jal || opcode == opc_jalr ||
                             (opcode == opc_branch && taken));
    assign jump_target_o = (opcode == opc_jal) ? if_id_i.pc + imm_j :
                           (opcode == opc_jalr) ? {jalr_sum[31:1], 1'b0} :
                           if_id_i.pc + imm_b;

    always_comb begin
        id_ex_d        = '0;
        id_ex_d.rd     = rd;
        id_ex_d.alu_op = alu_add;
        case (opcode)
            opc_op_imm: begin
                id_ex_d.valid   = live;
                id_ex_d.op1     = op_a;
                id_ex_d.op2     = imm_i;
                id_ex_d.alu_op  = alu_op_e'(funct3);
                id_ex_d.alu_alt = funct3 == 3'b101 && if_id_i.inst[30];  // srai only
                id_ex_d.wb      = 1'b1;
            end
            opc_op: begin
                id_ex_d.valid   = live;
                id_ex_d.op1     = op_a;
                id_ex_d.op2     = op_b;
                id_ex_d.alu_op  = alu_op_e'(funct3);
                id_ex_d.alu_alt = if_id_i.inst[30];
                id_ex_d.wb      = 1'b1;
            end
            opc_lui: begin
                id_ex_d.valid = live;
                id_ex_d.op1   = imm_u;
                id_ex_d.wb    = 1'b1;
            end
            opc_auipc: begin
                id_ex_d.valid = live;
                id_ex_d.op1   = imm_u;
                id_ex_d.op2   = if_id_i.pc;
                id_ex_d.wb    = 1'b1;
            end
            opc_jal, opc_jalr: begin
                id_ex_d.valid = live;
                id_ex_d.op1   = if_id_i.pc;  // link value
                id_ex_d.op2   = 32'd4;
                id_ex_d.wb    = 1'b1;
            end
            opc_load: begin
                id_ex_d.valid  = live;
                id_ex_d.op1    = op_a;
                id_ex_d.op2    = imm_i;
                id_ex_d.wb     = 1'b1;
                id_ex_d.mem_op = mem_load;
            end
            opc_store: begin
                id_ex_d.valid      = live;
                id_ex_d.op1        = op_a;
                id_ex_d.op2        = imm_s;
                id_ex_d.store_data = op_b;
                id_ex_d.mem_op     = mem_store;
            end
            default: ;  // branch, fence, unknown leave as bubble
        endcase
    end

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            squash_q      <= 1'b0;
            id_ex_o.valid <= 1'b0;
        end else if (!stall_i) begin
            squash_q <= jump_o;
            id_ex_o  <= id_ex_d;
        end else if (!next_stall_i) begin
            id_ex_o.valid <= 1'b0;
        end
    end

    a_jump_needs_valid: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        jump_o |-> if_id_i.valid);

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic            ctrl_clk,
    input  logic            ctrl_reset,
    input  logic            stall_i,
    input  logic            next_stall_i,
    input  rv_pkg::id_ex_t  id_ex_i,
    output rv_pkg::fwd_t    fwd_o,
    output logic            load_pending_o,
    output rv_pkg::ex_mem_t ex_mem_o
);
    import rv_pkg::*;

    word_t      result;
    logic [4:0] shamt;

    assign shamt = id_ex_i.op2[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            alu_add:  result = id_ex_i.alu_alt ? id_ex_i.op1 - id_ex_i.op2
                                               : id_ex_i.op1 + id_ex_i.op2;
            alu_sll:  result = id_ex_i.op1 << shamt;
            alu_slt:  result = {31'b0, $signed(id_ex_i.op1) < $signed(id_ex_i.op2)};
            alu_sltu: result = {31'b0, id_ex_i.op1 < id_ex_i.op2};
            alu_xor:  result = id_ex_i.op1 ^ id_ex_i.op2;
            alu_srx:  result = id_ex_i.alu_alt ? word_t'($signed(id_ex_i.op1) >>> shamt)
                                               : id_ex_i.op1 >> shamt;
            alu_or:   result = id_ex_i.op1 | id_ex_i.op2;
            default:  result = id_ex_i.op1 & id_ex_i.op2;
        endcase
    end

    // a load result is not known here, so it is held back from forwarding
    assign fwd_o.valid = id_ex_i.valid && id_ex_i.wb && id_ex_i.mem_op != mem_load &&
                         id_ex_i.rd != '0;
    assign fwd_o.rd    = id_ex_i.rd;
    assign fwd_o.data  = result;

    assign load_pending_o = id_ex_i.valid && id_ex_i.mem_op == mem_load;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            ex_mem_o.valid <= 1'b0;
        end else if (!stall_i) begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.result     <= result;  // address for loads and stores
            ex_mem_o.store_data <= id_ex_i.store_data;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.wb         <= id_ex_i.wb;
            ex_mem_o.mem_op     <= id_ex_i.mem_op;
        end else if (!next_stall_i) begin
            ex_mem_o.valid <= 1'b0;
        end
    end

endmodule

//--- verilog/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic            ctrl_clk,
    input  logic            ctrl_reset,
    input  logic            stall_i,
    input  logic            next_stall_i,
    input  rv_pkg::ex_mem_t ex_mem_i,
    output rv_pkg::word_t   dmem_addr_o,
    output rv_pkg::word_t   dmem_wdata_o,
    output logic            dmem_req_o,
    output logic            dmem_wr_o,
    input  rv_pkg::word_t   dmem_rdata_i,
    input  logic            dmem_rdy_i,
    output logic            busy_o,
    output rv_pkg::fwd_t    fwd_o,
    output rv_pkg::mem_wb_t mem_wb_o
);
    import rv_pkg::*;

    word_t wb_data;

    // word accesses only
    assign dmem_req_o   = ex_mem_i.valid && ex_mem_i.mem_op != mem_none;
    assign dmem_wr_o    = ex_mem_i.mem_op == mem_store;
    assign dmem_addr_o  = ex_mem_i.result;
    assign dmem_wdata_o = ex_mem_i.store_data;
    assign busy_o       = dmem_req_o && !dmem_rdy_i;

    // read data is only good in the rdy cycle, and decode waits until then
    assign wb_data = (ex_mem_i.mem_op == mem_load) ? dmem_rdata_i : ex_mem_i.result;

    assign fwd_o.valid = ex_mem_i.valid && ex_mem_i.wb && ex_mem_i.rd != '0;
    assign fwd_o.rd    = ex_mem_i.rd;
    assign fwd_o.data  = wb_data;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            mem_wb_o.valid <= 1'b0;
        end else if (!stall_i) begin
            mem_wb_o.valid  <= ex_mem_i.valid;
            mem_wb_o.result <= wb_data;
            mem_wb_o.rd     <= ex_mem_i.rd;
            mem_wb_o.wb     <= ex_mem_i.wb;
        end else if (!next_stall_i) begin
            mem_wb_o.valid <= 1'b0;
        end
    end

    a_store_needs_valid: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        (dmem_req_o && dmem_wr_o) |-> ex_mem_i.valid);

    // a waiting request keeps its address, data and direction
    a_dmem_req_hold: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        (dmem_req_o && !dmem_rdy_i) |=>
            dmem_req_o && $stable(dmem_addr_o) && $stable(dmem_wdata_o) &&
            $stable(dmem_wr_o));

    // a completed store never writes a register
    a_store_no_wb: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        (dmem_req_o && dmem_wr_o && dmem_rdy_i) |=> !(mem_wb_o.valid && mem_wb_o.wb));

endmodule

//--- verilog/riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
    parameter rv_pkg::word_t pc_reset = 32'h00100000
) (
    input  logic          ctrl_clk,
    input  logic          ctrl_reset,
    output rv_pkg::word_t imem_addr_o,
    output logic          imem_req_o,
    input  rv_pkg::word_t imem_data_i,
    input  logic          imem_rdy_i,
    output rv_pkg::word_t dmem_addr_o,
    output rv_pkg::word_t dmem_wdata_o,
    output logic          dmem_req_o,
    output logic          dmem_wr_o,
    input  rv_pkg::word_t dmem_rdata_i,
    input  logic          dmem_rdy_i
);
    import rv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    fwd_t      fwd_ex, fwd_mem;
    reg_addr_t raddr1, raddr2;
    word_t     rdata1, rdata2, jump_target;
    logic      jump, load_pending;
    logic      fetch_busy, decode_busy, mem_busy;
    logic      fetch_stall, decode_stall, execute_stall, mem_stall;

    // decode also waits on fetch so a pending jump is not dropped
    assign fetch_stall   = fetch_busy || decode_busy || mem_busy;
    assign decode_stall  = fetch_busy || decode_busy || mem_busy;
    assign execute_stall = mem_busy;
    assign mem_stall     = mem_busy;

    register_file i_regs (
        .ctrl_clk (ctrl_clk),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .waddr_i  (mem_wb.rd),
        .wdata_i  (mem_wb.result),
        .wen_i    (mem_wb.valid && mem_wb.wb)
    );

    fetch_stage #(.pc_reset(pc_reset)) i_fetch (
        .ctrl_clk(ctrl_clk), .ctrl_reset(ctrl_reset),
        .stall_i(fetch_stall), .next_stall_i(decode_stall),
        .jump_i(jump), .jump_target_i(jump_target),
        .imem_addr_o(imem_addr_o), .imem_req_o(imem_req_o),
        .imem_data_i(imem_data_i), .imem_rdy_i(imem_rdy_i),
        .busy_o(fetch_busy), .if_id_o(if_id)
    );

    decode_stage i_decode (
        .ctrl_clk(ctrl_clk), .ctrl_reset(ctrl_reset),
        .stall_i(decode_stall), .next_stall_i(execute_stall),
        .if_id_i(if_id),
        .raddr1_o(raddr1), .raddr2_o(raddr2), .rdata1_i(rdata1), .rdata2_i(rdata2),
        .fwd_ex_i(fwd_ex), .fwd_mem_i(fwd_mem), .load_pending_i(load_pending),
        .jump_o(jump), .jump_target_o(jump_target),
        .busy_o(decode_busy), .id_ex_o(id_ex)
    );

    execute_stage i_execute (
        .ctrl_clk(ctrl_clk), .ctrl_reset(ctrl_reset),
        .stall_i(execute_stall), .next_stall_i(mem_stall),
        .id_ex_i(id_ex), .fwd_o(fwd_ex), .load_pending_o(load_pending),
        .ex_mem_o(ex_mem)
    );

    memory_stage i_memory (
        .ctrl_clk(ctrl_clk), .ctrl_reset(ctrl_reset),
        .stall_i(mem_stall), .next_stall_i(1'b0),  // write-back never stalls
        .ex_mem_i(ex_mem),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
        .dmem_req_o(dmem_req_o), .dmem_wr_o(dmem_wr_o),
        .dmem_rdata_i(dmem_rdata_i), .dmem_rdy_i(dmem_rdy_i),
        .busy_o(mem_busy), .fwd_o(fwd_mem), .mem_wb_o(mem_wb)
    );

endmodule

//--- dv/core_mem_model.sv
`timescale 1ns/1ps

module core_mem_model #(
    parameter int            depth_words = 64,
    parameter rv_pkg::word_t base_addr   = '0
) (
    input  logic          ctrl_clk,
    input  logic          ctrl_reset,
    input  rv_pkg::word_t image_i [depth_words],
    input  rv_pkg::word_t addr_i,
    input  logic          req_i,
    input  logic          wr_i,
    input  rv_pkg::word_t wdata_i,
    output rv_pkg::word_t rdata_o,
    output logic          rdy_o
);
    import rv_pkg::*;

    localparam int aw = $clog2(depth_words);

    word_t         mem [depth_words];
    word_t         offset;
    logic [aw-1:0] idx;
    logic          rdy_q;

    assign offset  = addr_i - base_addr;
    assign idx     = offset[aw+1:2];  // wraps outside the window
    assign rdata_o = ctrl_reset ? '0 : mem[idx];  // same-cycle read data
    assign rdy_o   = !ctrl_reset && rdy_q;

    // ready about 70 % of cycles, whether or not a request is up
    always_ff @(posedge ctrl_clk) begin
        rdy_q <= ($urandom % 10) < 7;
    end

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            mem <= image_i;  // image reloaded on every reset
        end else if (req_i && wr_i && rdy_o) begin
            mem[idx] <= wdata_i;
        end
    end

endmodule

//--- dv/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import rv_pkg::*;

    localparam word_t pc_reset    = 32'h00100000;
    localparam word_t data_base   = 32'h00002000;
    localparam int    rom_words   = 64;
    localparam int    ram_words   = 64;
    localparam int    num_stores  = 8;
    // 39 instructions, a handful of cycles each at 70 % ready, plenty of margin
    localparam int    max_cycles  = 2000;
    localparam word_t poison_addr = 32'h00002080;
    localparam word_t link_addr   = 32'h00002014;
    localparam word_t jal_pc      = pc_reset + 32'd112;  // jal x16 at word 28

    localparam word_t exp_addr [num_stores] = '{
        32'h00002000, 32'h00002004, 32'h00002008, 32'h0000200c,
        32'h00002010, 32'h00002014, 32'h00002018, 32'h0000201c};
    localparam word_t exp_data [num_stores] = '{
        32'h12345678, 32'h00101015, 32'h12244668, 32'hfffffffd,
        32'h1234567d, 32'h00100074, 32'h00100080, 32'h00000007};

    logic  ctrl_clk   = 1'b0;
    logic  ctrl_reset = 1'b1;
    word_t imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
    logic  imem_req, imem_rdy, dmem_req, dmem_wr, dmem_rdy;
    word_t rom_image [rom_words];
    word_t ram_image [ram_words];
    int    store_count;
    int    cycle_count;
    logic  store_done;
    logic  imem_wait_q, dmem_wait_q, dmem_wr_q;
    word_t imem_addr_q, dmem_addr_q, dmem_wdata_q;

    function automatic word_t r_type(int f7, int rd, int f3, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
    endfunction

    function automatic word_t i_type(opcode_e op, int rd, int f3, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t s_type(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic word_t b_type(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                opc_branch};
    endfunction

    function automatic word_t u_type(opcode_e op, int rd, int imm20);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic word_t j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
    endfunction

    function automatic word_t fill_word(word_t addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1e995;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    riscv_core #(.pc_reset(pc_reset)) i_dut (
        .ctrl_clk(ctrl_clk), .ctrl_reset(ctrl_reset),
        .imem_addr_o(imem_addr), .imem_req_o(imem_req),
        .imem_data_i(imem_data), .imem_rdy_i(imem_rdy),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
        .dmem_req_o(dmem_req), .dmem_wr_o(dmem_wr),
        .dmem_rdata_i(dmem_rdata), .dmem_rdy_i(dmem_rdy)
    );

    core_mem_model #(.depth_words(rom_words), .base_addr(pc_reset)) i_imem (
        .ctrl_clk(ctrl_clk), .ctrl_reset(ctrl_reset), .image_i(rom_image),
        .addr_i(imem_addr), .req_i(imem_req), .wr_i(1'b0), .wdata_i('0),
        .rdata_o(imem_data), .rdy_o(imem_rdy)
    );

    core_mem_model #(.depth_words(ram_words), .base_addr(data_base)) i_dmem (
        .ctrl_clk(ctrl_clk), .ctrl_reset(ctrl_reset), .image_i(ram_image),
        .addr_i(dmem_addr), .req_i(dmem_req), .wr_i(dmem_wr), .wdata_i(dmem_wdata),
        .rdata_o(dmem_rdata), .rdy_o(dmem_rdy)
    );

    initial forever #2 ctrl_clk = ~ctrl_clk;

    initial begin
        void'($urandom(32'he0fa65a0));
        for (int i = 0; i < rom_words; i++) begin
            rom_image[i] = fill_word(pc_reset + word_t'(4 * i));
        end
        for (int i = 0; i < ram_words; i++) begin
            ram_image[i] = fill_word(data_base + word_t'(4 * i));
        end
        rom_image[0]  = u_type(opc_lui, 10, 'h2);               // x10 = data base
        rom_image[1]  = u_type(opc_lui, 1, 'h12345);
        rom_image[2]  = i_type(opc_op_imm, 1, 0, 1, 'h678);     // x1 from execute
        rom_image[3]  = s_type(1, 10, 0);
        rom_image[4]  = u_type(opc_auipc, 2, 'h1);
        rom_image[5]  = i_type(opc_op_imm, 3, 0, 0, 5);
        rom_image[6]  = r_type(0, 4, 0, 2, 3);                  // x2 via memory stage
        rom_image[7]  = r_type('h20, 5, 0, 4, 3);               // sub
        rom_image[8]  = r_type(0, 6, 4, 5, 1);                  // xor
        rom_image[9]  = s_type(4, 10, 4);
        rom_image[10] = s_type(6, 10, 8);
        rom_image[11] = r_type('h20, 7, 0, 0, 3);               // x7 = -5
        rom_image[12] = i_type(opc_op_imm, 8, 5, 7, 'h401);     // srai 1
        rom_image[13] = s_type(8, 10, 12);
        rom_image[14] = i_type(opc_load, 12, 2, 10, 0);
        rom_image[15] = r_type(0, 13, 0, 12, 3);                // load-use
        rom_image[16] = s_type(13, 10, 16);
        rom_image[17] = i_type(opc_op_imm, 14, 0, 0, -1);       // poison word
        rom_image[18] = b_type(0, 3, 3, 8);                     // beq taken
        rom_image[19] = s_type(14, 10, 'h80);
        rom_image[20] = b_type(1, 3, 0, 8);                     // bne taken
        rom_image[21] = s_type(14, 10, 'h80);
        rom_image[22] = b_type(4, 7, 3, 8);                     // blt taken
        rom_image[23] = s_type(14, 10, 'h80);
        rom_image[24] = b_type(7, 7, 3, 8);                     // bgeu taken
        rom_image[25] = s_type(14, 10, 'h80);
        rom_image[26] = b_type(5, 7, 3, 8);                     // bge falls through
        rom_image[27] = i_type(opc_op_imm, 15, 0, 0, 7);
        rom_image[28] = j_type(16, 8);
        rom_image[29] = s_type(14, 10, 'h80);
        rom_image[30] = u_type(opc_auipc, 17, 0);
        rom_image[31] = i_type(opc_jalr, 18, 0, 17, 16);        // to word 34
        rom_image[32] = s_type(14, 10, 'h80);
        rom_image[33] = s_type(14, 10, 'h80);
        rom_image[34] = s_type(16, 10, 'h14);
        rom_image[35] = s_type(18, 10, 'h18);
        rom_image[36] = s_type(15, 10, 'h1c);
        rom_image[37] = i_type(opc_fence, 0, 0, 0, 'h0ff);
        rom_image[38] = j_type(0, 0);                           // park
        repeat (2) @(posedge ctrl_clk);
        ctrl_reset <= 1'b0;
        wait (store_count == num_stores);
        repeat (20) @(posedge ctrl_clk);
        $display("Regression passed");
        $finish;
    end

    assign store_done = dmem_req && dmem_wr && dmem_rdy;

    always @(posedge ctrl_clk) begin
        cycle_count  <= cycle_count + 1;
        imem_wait_q  <= imem_req && !imem_rdy;
        imem_addr_q  <= imem_addr;
        dmem_wait_q  <= dmem_req && !dmem_rdy;
        dmem_addr_q  <= dmem_addr;
        dmem_wdata_q <= dmem_wdata;
        dmem_wr_q    <= dmem_wr;
        if (ctrl_reset) begin
            store_count <= 0;
        end else if (store_done) begin
            store_count <= store_count + 1;
        end
        if (cycle_count >= max_cycles) begin
            fail_run($sformatf("timeout after %0d cycles, only %0d of %0d stores seen",
                               cycle_count, store_count, num_stores));
        end
    end

    a_reset_pc: assert property (@(posedge ctrl_clk)
        $fell(ctrl_reset) |-> imem_addr == pc_reset)
        else fail_run($sformatf("CHECK FAILED time=%0t imem_addr_o expected=%h actual=%h",
                                $time, pc_reset, $sampled(imem_addr)));

    a_reset_req: assert property (@(posedge ctrl_clk)
        $fell(ctrl_reset) |-> imem_req && !dmem_req)
        else fail_run($sformatf("CHECK FAILED time=%0t {imem_req_o,dmem_req_o} expected=%b actual=%b",
                                $time, 2'b10, {$sampled(imem_req), $sampled(dmem_req)}));

    a_imem_hold: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        imem_wait_q |-> imem_addr == imem_addr_q)
        else fail_run($sformatf("CHECK FAILED time=%0t imem_addr_o expected=%h actual=%h",
                                $time, $sampled(imem_addr_q), $sampled(imem_addr)));

    a_dmem_hold_addr: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        dmem_wait_q |-> dmem_addr == dmem_addr_q)
        else fail_run($sformatf("CHECK FAILED time=%0t dmem_addr_o expected=%h actual=%h",
                                $time, $sampled(dmem_addr_q), $sampled(dmem_addr)));

    a_dmem_hold_data: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        dmem_wait_q |-> dmem_wdata == dmem_wdata_q)
        else fail_run($sformatf("CHECK FAILED time=%0t dmem_wdata_o expected=%h actual=%h",
                                $time, $sampled(dmem_wdata_q), $sampled(dmem_wdata)));

    a_dmem_hold_ctl: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        dmem_wait_q |-> dmem_req && dmem_wr == dmem_wr_q)
        else fail_run($sformatf("CHECK FAILED time=%0t {dmem_req_o,dmem_wr_o} expected=%b actual=%b",
                                $time, {1'b1, $sampled(dmem_wr_q)},
                                {$sampled(dmem_req), $sampled(dmem_wr)}));

    a_no_extra_store: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        store_done |-> store_count < num_stores)
        else fail_run($sformatf("unexpected extra store to %h at time %0t",
                                $sampled(dmem_addr), $time));

    a_no_poison: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        store_done |-> dmem_addr != poison_addr)
        else fail_run($sformatf("skipped instruction stored to poison address %h at time %0t",
                                poison_addr, $time));

    // stores checked in program order
    a_store_addr: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        store_done && store_count < num_stores |-> dmem_addr == exp_addr[store_count])
        else fail_run($sformatf("CHECK FAILED time=%0t dmem_addr_o expected=%h actual=%h",
                                $time, exp_addr[$sampled(store_count)], $sampled(dmem_addr)));

    a_store_data: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        store_done && store_count < num_stores |-> dmem_wdata == exp_data[store_count])
        else fail_run($sformatf("CHECK FAILED time=%0t dmem_wdata_o expected=%h actual=%h",
                                $time, exp_data[$sampled(store_count)], $sampled(dmem_wdata)));

    a_jal_link: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        store_done && dmem_addr == link_addr |-> dmem_wdata == jal_pc + 32'd4)
        else fail_run($sformatf("CHECK FAILED time=%0t dmem_wdata_o expected=%h actual=%h",
                                $time, jal_pc + 32'd4, $sampled(dmem_wdata)));

endmodule

//--- flist.f
verilog/rv_pkg.sv
verilog/register_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/riscv_core.sv
dv/core_mem_model.sv
dv/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= core_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
